//--- rtl/odd_pipe_pkg.sv
//////////////////////////////////////////////////
// Odd pipe package
// Widths, latencies, local store geometry and the
// opcode and shift mode encodings of the odd pipe
//////////////////////////////////////////////////

package odd_pipe_pkg;

    // Datapath widths
    localparam int QUAD_W         = 128;
    localparam int WORD_W         = 32;
    localparam int BYTES_PER_QUAD = 16;
    localparam int REG_ADDR_W     = 7;

    // Immediate fields
    localparam int IMM7_W  = 7;
    localparam int IMM10_W = 10;
    localparam int IMM16_W = 16;

    // Issue to writeback, in cycles
    localparam int PERM_LATENCY = 4;
    localparam int LS_LATENCY   = 6;

    // Local store of 64 quadwords, address wraps at 1 KiB
    localparam int LS_DEPTH   = 64;
    localparam int LS_INDEX_W = 6;

    typedef enum logic [4:0] {
        shlqbi,
        shlqbii,
        shlqby,
        shlqbyi,
        shlqbybi,
        rotqbi,
        rotqbii,
        rotqby,
        rotqbyi,
        rotqbybi,
        shufb,
        lqd,
        lqx,
        lqa,
        stqd,
        stqx,
        stqa,
        lnop
    } odd_opcode_t;

    typedef enum logic [1:0] {
        shift_bits,
        shift_bytes,
        rotate_bits,
        rotate_bytes
    } shift_mode_t;

endpackage

//--- rtl/quad_shift_rotate.sv
//////////////////////////////////////////////////
// Quadword shifter
// Shifts or rotates a quadword toward byte 0 by
// bits or by bytes, purely combinational
//////////////////////////////////////////////////

`timescale 1ns/1ps

module quad_shift_rotate (
    input  logic [odd_pipe_pkg::QUAD_W-1:0] value,
    input  odd_pipe_pkg::shift_mode_t       mode,
    input  logic [4:0]                      count,
    output logic [odd_pipe_pkg::QUAD_W-1:0] result
);

    localparam int QW = odd_pipe_pkg::QUAD_W;

    logic [6:0]      shamt;
    logic [QW-1:0]   shifted;
    logic [2*QW-1:0] doubled;
    logic [QW-1:0]   rotated;
    logic            byte_overflow;

    // Bit modes use count bits 2:0, byte modes count mod 16 in bytes
    always_comb begin
        if (mode == odd_pipe_pkg::shift_bits || mode == odd_pipe_pkg::rotate_bits) begin
            shamt = {4'b0000, count[2:0]};
        end else begin
            shamt = {count[3:0], 3'b000};
        end
    end

    assign shifted = value << shamt;

    // Upper half of the doubled word holds the left rotate
    assign doubled = {value, value} << shamt;
    assign rotated = doubled[2*QW-1 -: QW];

    assign byte_overflow = (count >= odd_pipe_pkg::BYTES_PER_QUAD);

    always_comb begin
        case (mode)
            odd_pipe_pkg::shift_bits: begin
                result = shifted;
            end
            odd_pipe_pkg::shift_bytes: begin
                result = byte_overflow ? '0 : shifted;
            end
            odd_pipe_pkg::rotate_bits,
            odd_pipe_pkg::rotate_bytes: begin
                result = rotated;
            end
            default: begin
                result = shifted;
            end
        endcase
    end

endmodule

//--- rtl/byte_shuffler.sv
//////////////////////////////////////////////////
// Byte shuffler
// Builds each result byte from ra:rb or a constant
// pattern, as chosen by the matching control byte
//////////////////////////////////////////////////

`timescale 1ns/1ps

module byte_shuffler (
    input  logic [odd_pipe_pkg::QUAD_W-1:0] ra,
    input  logic [odd_pipe_pkg::QUAD_W-1:0] rb,
    input  logic [odd_pipe_pkg::QUAD_W-1:0] control,
    output logic [odd_pipe_pkg::QUAD_W-1:0] result
);

    localparam int QW = odd_pipe_pkg::QUAD_W;

    logic [2*QW-1:0] concat;
    logic [7:0]      ctl;
    logic [4:0]      sel;

    assign concat = {ra, rb};

    // Byte 0 is the most significant byte of each operand
    always_comb begin
        result = '0;
        ctl = '0;
        sel = '0;
        for (int j = 0; j < odd_pipe_pkg::BYTES_PER_QUAD; j++) begin
            ctl = control[QW-1-8*j -: 8];
            sel = ctl[4:0];
            if (ctl[7:6] == 2'b10) begin
                result[QW-1-8*j -: 8] = 8'h00;
            end else if (ctl[7:5] == 3'b110) begin
                result[QW-1-8*j -: 8] = 8'hff;
            end else if (ctl[7:5] == 3'b111) begin
                result[QW-1-8*j -: 8] = 8'h80;
            end else begin
                result[QW-1-8*j -: 8] = concat[2*QW-1-8*sel -: 8];
            end
        end
    end

endmodule

//--- rtl/permute_unit.sv
//////////////////////////////////////////////////
// Permute unit
// Quadword shifts, rotates and byte shuffle with a
// fixed latency of PERM_LATENCY cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps

module permute_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                issue_valid,
    input  odd_pipe_pkg::odd_opcode_t           opcode,
    input  logic [odd_pipe_pkg::QUAD_W-1:0]     ra,
    input  logic [odd_pipe_pkg::QUAD_W-1:0]     rb,
    input  logic [odd_pipe_pkg::QUAD_W-1:0]     rc,
    input  logic [odd_pipe_pkg::REG_ADDR_W-1:0] rt_addr,
    input  logic [odd_pipe_pkg::IMM7_W-1:0]     imm7,
    output logic                                wb_valid,
    output logic [odd_pipe_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [odd_pipe_pkg::QUAD_W-1:0]     wb_data
);

    localparam int QW  = odd_pipe_pkg::QUAD_W;
    localparam int LAT = odd_pipe_pkg::PERM_LATENCY;

    logic                                valid_q;
    odd_pipe_pkg::odd_opcode_t           op_q;
    logic [QW-1:0]                       ra_q;
    logic [QW-1:0]                       rb_q;
    logic [QW-1:0]                       rc_q;
    logic [odd_pipe_pkg::REG_ADDR_W-1:0] rt_q;
    logic [odd_pipe_pkg::IMM7_W-1:0]     imm7_q;

    logic [odd_pipe_pkg::WORD_W-1:0]     pw;
    odd_pipe_pkg::shift_mode_t           mode;
    logic [4:0]                          count;
    logic                                is_perm;
    logic                                is_shuf;
    logic [QW-1:0]                       shift_result;
    logic [QW-1:0]                       shuf_result;
    logic [QW-1:0]                       result;

    logic [LAT-1:0]                      vld_pipe;
    logic [odd_pipe_pkg::REG_ADDR_W-1:0] addr_pipe [LAT];
    logic [QW-1:0]                       data_pipe [LAT];

    // Operand capture at issue
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        op_q   <= opcode;
        ra_q   <= ra;
        rb_q   <= rb;
        rc_q   <= rc;
        rt_q   <= rt_addr;
        imm7_q <= imm7;
    end

    assign pw = rb_q[QW-1 -: odd_pipe_pkg::WORD_W];

    // Count source and shift mode per opcode
    always_comb begin
        mode    = odd_pipe_pkg::shift_bits;
        count   = '0;
        is_perm = 1'b1;
        is_shuf = 1'b0;
        case (op_q)
            odd_pipe_pkg::shlqbi:   count = {2'b00, pw[2:0]};
            odd_pipe_pkg::shlqbii:  count = {2'b00, imm7_q[2:0]};
            odd_pipe_pkg::shlqby: begin
                mode  = odd_pipe_pkg::shift_bytes;
                count = pw[4:0];
            end
            odd_pipe_pkg::shlqbyi: begin
                mode  = odd_pipe_pkg::shift_bytes;
                count = imm7_q[4:0];
            end
            odd_pipe_pkg::shlqbybi: begin
                mode  = odd_pipe_pkg::shift_bytes;
                count = pw[7:3];
            end
            odd_pipe_pkg::rotqbi: begin
                mode  = odd_pipe_pkg::rotate_bits;
                count = {2'b00, pw[2:0]};
            end
            odd_pipe_pkg::rotqbii: begin
                mode  = odd_pipe_pkg::rotate_bits;
                count = {2'b00, imm7_q[2:0]};
            end
            odd_pipe_pkg::rotqby: begin
                mode  = odd_pipe_pkg::rotate_bytes;
                count = {1'b0, pw[3:0]};
            end
            odd_pipe_pkg::rotqbyi: begin
                mode  = odd_pipe_pkg::rotate_bytes;
                count = {1'b0, imm7_q[3:0]};
            end
            odd_pipe_pkg::rotqbybi: begin
                mode  = odd_pipe_pkg::rotate_bytes;
                count = pw[7:3];
            end
            odd_pipe_pkg::shufb:    is_shuf = 1'b1;
            default:                is_perm = 1'b0;
        endcase
    end

    quad_shift_rotate u_shift (
        .value  (ra_q),
        .mode   (mode),
        .count  (count),
        .result (shift_result)
    );

    byte_shuffler u_shuffle (
        .ra      (ra_q),
        .rb      (rb_q),
        .control (rc_q),
        .result  (shuf_result)
    );

    assign result = is_shuf ? shuf_result : shift_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[LAT-2:0], valid_q & is_perm};
        end
    end

    always_ff @(posedge clk) begin
        addr_pipe[0] <= rt_q;
        data_pipe[0] <= result;
        for (int i = 1; i < LAT; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign wb_valid = vld_pipe[LAT-1];
    assign wb_addr  = addr_pipe[LAT-1];
    assign wb_data  = data_pipe[LAT-1];

endmodule

//--- rtl/local_store_ram.sv
//////////////////////////////////////////////////
// Local store array
// Single port quadword RAM, synchronous read and
// write, write-first on the same index
//////////////////////////////////////////////////

`timescale 1ns/1ps

module local_store_ram (
    input  logic                                clk,
    input  logic [odd_pipe_pkg::LS_INDEX_W-1:0] index,
    input  logic                                write_en,
    input  logic [odd_pipe_pkg::QUAD_W-1:0]     write_data,
    output logic [odd_pipe_pkg::QUAD_W-1:0]     read_data
);

    logic [odd_pipe_pkg::QUAD_W-1:0] mem [odd_pipe_pkg::LS_DEPTH];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[index] <= write_data;
        end
    end

    // Read port returns the new data during a write
    always_ff @(posedge clk) begin
        if (write_en) begin
            read_data <= write_data;
        end else begin
            read_data <= mem[index];
        end
    end

endmodule

//--- rtl/load_store_unit.sv
//////////////////////////////////////////////////
// Load/store unit
// d-, x- and a-form address generation, local
// store access and load writeback at LS_LATENCY
//////////////////////////////////////////////////

`timescale 1ns/1ps

module load_store_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                issue_valid,
    input  odd_pipe_pkg::odd_opcode_t           opcode,
    input  logic [odd_pipe_pkg::QUAD_W-1:0]     ra,
    input  logic [odd_pipe_pkg::QUAD_W-1:0]     rb,
    input  logic [odd_pipe_pkg::QUAD_W-1:0]     rc,
    input  logic [odd_pipe_pkg::REG_ADDR_W-1:0] rt_addr,
    input  logic [odd_pipe_pkg::IMM10_W-1:0]    imm10,
    input  logic [odd_pipe_pkg::IMM16_W-1:0]    imm16,
    output logic                                wb_valid,
    output logic [odd_pipe_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [odd_pipe_pkg::QUAD_W-1:0]     wb_data
);

    localparam int QW  = odd_pipe_pkg::QUAD_W;
    localparam int WW  = odd_pipe_pkg::WORD_W;
    localparam int LAT = odd_pipe_pkg::LS_LATENCY;
    localparam int IW  = odd_pipe_pkg::LS_INDEX_W;

    logic [WW-1:0]                       pw_a;
    logic [WW-1:0]                       pw_b;
    logic [WW-1:0]                       d_offset;
    logic [WW-1:0]                       a_addr;
    logic [WW-1:0]                       ea;
    logic [WW-1:0]                       lsa;
    logic [IW-1:0]                       index;
    logic                                is_load;
    logic                                is_store;
    logic [QW-1:0]                       read_data;

    logic                                ld_valid_q;
    logic [odd_pipe_pkg::REG_ADDR_W-1:0] ld_addr_q;
    logic [LAT-1:0]                      vld_pipe;
    logic [odd_pipe_pkg::REG_ADDR_W-1:0] addr_pipe [LAT];
    logic [QW-1:0]                       data_pipe [LAT];

    assign pw_a = ra[QW-1 -: WW];
    assign pw_b = rb[QW-1 -: WW];

    assign d_offset = {{(WW-odd_pipe_pkg::IMM10_W-4){imm10[odd_pipe_pkg::IMM10_W-1]}},
                       imm10, 4'b0000};
    assign a_addr   = {{(WW-odd_pipe_pkg::IMM16_W-2){imm16[odd_pipe_pkg::IMM16_W-1]}},
                       imm16, 2'b00};

    always_comb begin
        ea       = pw_a + d_offset;
        is_load  = 1'b0;
        is_store = 1'b0;
        case (opcode)
            odd_pipe_pkg::lqd:  is_load = 1'b1;
            odd_pipe_pkg::lqx: begin
                ea      = pw_a + pw_b;
                is_load = 1'b1;
            end
            odd_pipe_pkg::lqa: begin
                ea      = a_addr;
                is_load = 1'b1;
            end
            odd_pipe_pkg::stqd: is_store = 1'b1;
            odd_pipe_pkg::stqx: begin
                ea       = pw_a + pw_b;
                is_store = 1'b1;
            end
            odd_pipe_pkg::stqa: begin
                ea       = a_addr;
                is_store = 1'b1;
            end
            default: ;
        endcase
    end

    // Quadword aligned, wraps modulo the store size
    assign lsa   = {ea[WW-1:4], 4'b0000};
    assign index = lsa[IW+3:4];

    local_store_ram u_ram (
        .clk        (clk),
        .index      (index),
        .write_en   (issue_valid & is_store),
        .write_data (rc),
        .read_data  (read_data)
    );

    // Load tag rides alongside the RAM read
    always_ff @(posedge clk) begin
        if (reset) begin
            ld_valid_q <= 1'b0;
            vld_pipe   <= '0;
        end else begin
            ld_valid_q <= issue_valid & is_load;
            vld_pipe   <= {vld_pipe[LAT-2:0], ld_valid_q};
        end
    end

    always_ff @(posedge clk) begin
        ld_addr_q    <= rt_addr;
        addr_pipe[0] <= ld_addr_q;
        data_pipe[0] <= read_data;
        for (int i = 1; i < LAT; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign wb_valid = vld_pipe[LAT-1];
    assign wb_addr  = addr_pipe[LAT-1];
    assign wb_data  = data_pipe[LAT-1];

endmodule

//--- rtl/odd_pipe_top.sv
//////////////////////////////////////////////////
// Odd execution pipe
// Fans the issue port out to the permute and
// load/store units, one writeback port per unit
//////////////////////////////////////////////////

`timescale 1ns/1ps

module odd_pipe_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                issue_valid,
    input  odd_pipe_pkg::odd_opcode_t           opcode,
    input  logic [odd_pipe_pkg::QUAD_W-1:0]     ra,
    input  logic [odd_pipe_pkg::QUAD_W-1:0]     rb,
    input  logic [odd_pipe_pkg::QUAD_W-1:0]     rc,
    input  logic [odd_pipe_pkg::REG_ADDR_W-1:0] rt_addr,
    input  logic [odd_pipe_pkg::IMM7_W-1:0]     imm7,
    input  logic [odd_pipe_pkg::IMM10_W-1:0]    imm10,
    input  logic [odd_pipe_pkg::IMM16_W-1:0]    imm16,
    output logic                                perm_wb_valid,
    output logic [odd_pipe_pkg::REG_ADDR_W-1:0] perm_wb_addr,
    output logic [odd_pipe_pkg::QUAD_W-1:0]     perm_wb_data,
    output logic                                ls_wb_valid,
    output logic [odd_pipe_pkg::REG_ADDR_W-1:0] ls_wb_addr,
    output logic [odd_pipe_pkg::QUAD_W-1:0]     ls_wb_data
);

    // Each unit ignores opcodes outside its own class
    permute_unit u_perm (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .opcode      (opcode),
        .ra          (ra),
        .rb          (rb),
        .rc          (rc),
        .rt_addr     (rt_addr),
        .imm7        (imm7),
        .wb_valid    (perm_wb_valid),
        .wb_addr     (perm_wb_addr),
        .wb_data     (perm_wb_data)
    );

    load_store_unit u_ls (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .opcode      (opcode),
        .ra          (ra),
        .rb          (rb),
        .rc          (rc),
        .rt_addr     (rt_addr),
        .imm10       (imm10),
        .imm16       (imm16),
        .wb_valid    (ls_wb_valid),
        .wb_addr     (ls_wb_addr),
        .wb_data     (ls_wb_data)
    );

endmodule

//--- testbench/odd_pipe_checker.sv
//////////////////////////////////////////////////
// Odd pipe checker
// Reference model of the permute and load/store
// rules, with assertions on both writeback ports
//////////////////////////////////////////////////

`timescale 1ns/1ps

module odd_pipe_checker (
    input logic                                clk,
    input logic                                reset,
    input logic                                issue_valid,
    input odd_pipe_pkg::odd_opcode_t           opcode,
    input logic [odd_pipe_pkg::QUAD_W-1:0]     ra,
    input logic [odd_pipe_pkg::QUAD_W-1:0]     rb,
    input logic [odd_pipe_pkg::QUAD_W-1:0]     rc,
    input logic [odd_pipe_pkg::REG_ADDR_W-1:0] rt_addr,
    input logic [odd_pipe_pkg::IMM7_W-1:0]     imm7,
    input logic [odd_pipe_pkg::IMM10_W-1:0]    imm10,
    input logic [odd_pipe_pkg::IMM16_W-1:0]    imm16,
    input logic                                perm_wb_valid,
    input logic [odd_pipe_pkg::REG_ADDR_W-1:0] perm_wb_addr,
    input logic [odd_pipe_pkg::QUAD_W-1:0]     perm_wb_data,
    input logic                                ls_wb_valid,
    input logic [odd_pipe_pkg::REG_ADDR_W-1:0] ls_wb_addr,
    input logic [odd_pipe_pkg::QUAD_W-1:0]     ls_wb_data
);

    localparam int QW = odd_pipe_pkg::QUAD_W;
    localparam int AW = odd_pipe_pkg::REG_ADDR_W;
    localparam int PL = odd_pipe_pkg::PERM_LATENCY;
    localparam int LL = odd_pipe_pkg::LS_LATENCY;

    int errors = 0;

    // Expected results, entry k holds the issue from k edges back
    logic [PL:0]   pv;
    logic [AW-1:0] pa [PL+1];
    logic [QW-1:0] pd [PL+1];
    logic [LL:0]   lv;
    logic [AW-1:0] la [LL+1];
    logic [QW-1:0] ld [LL+1];
    logic [QW-1:0] shadow [odd_pipe_pkg::LS_DEPTH];

    function automatic logic [QW-1:0] shuffle_model(
        input logic [QW-1:0] a,
        input logic [QW-1:0] b,
        input logic [QW-1:0] c
    );
        logic [7:0]    src [32];
        logic [7:0]    ctl;
        logic [QW-1:0] res;
        res = '0;
        for (int k = 0; k < 16; k++) begin
            src[k]    = a[QW-1-8*k -: 8];
            src[k+16] = b[QW-1-8*k -: 8];
        end
        for (int j = 0; j < 16; j++) begin
            ctl = c[QW-1-8*j -: 8];
            casez (ctl)
                8'b10??????: res[QW-1-8*j -: 8] = 8'h00;
                8'b110?????: res[QW-1-8*j -: 8] = 8'hff;
                8'b111?????: res[QW-1-8*j -: 8] = 8'h80;
                default:     res[QW-1-8*j -: 8] = src[ctl[4:0]];
            endcase
        end
        return res;
    endfunction

    function automatic logic [QW-1:0] perm_model(
        input odd_pipe_pkg::odd_opcode_t op,
        input logic [QW-1:0]             a,
        input logic [QW-1:0]             b,
        input logic [QW-1:0]             c,
        input logic [6:0]                i7
    );
        logic [31:0] pw;
        int          bits;
        logic        rot;
        pw   = b[QW-1 -: 32];
        bits = 0;
        rot  = 1'b0;
        case (op)
            odd_pipe_pkg::shlqbi:   bits = int'(pw[2:0]);
            odd_pipe_pkg::shlqbii:  bits = int'(i7[2:0]);
            odd_pipe_pkg::shlqby:   bits = 8 * int'(pw[4:0]);
            odd_pipe_pkg::shlqbyi:  bits = 8 * int'(i7[4:0]);
            odd_pipe_pkg::shlqbybi: bits = 8 * int'(pw[7:3]);
            odd_pipe_pkg::rotqbi: begin
                rot  = 1'b1;
                bits = int'(pw[2:0]);
            end
            odd_pipe_pkg::rotqbii: begin
                rot  = 1'b1;
                bits = int'(i7[2:0]);
            end
            odd_pipe_pkg::rotqby: begin
                rot  = 1'b1;
                bits = 8 * int'(pw[3:0]);
            end
            odd_pipe_pkg::rotqbyi: begin
                rot  = 1'b1;
                bits = 8 * int'(i7[3:0]);
            end
            odd_pipe_pkg::rotqbybi: begin
                rot  = 1'b1;
                bits = 8 * (int'(pw[7:3]) % 16);
            end
            odd_pipe_pkg::shufb: return shuffle_model(a, b, c);
            default: return '0;
        endcase
        // Rotate wraps, a shift past the top leaves zero
        if (rot) begin
            return (a << bits) | (a >> (QW - bits));
        end
        return (bits >= QW) ? '0 : (a << bits);
    endfunction

    function automatic logic [odd_pipe_pkg::LS_INDEX_W-1:0] ls_index(
        input odd_pipe_pkg::odd_opcode_t op,
        input logic [QW-1:0]             a,
        input logic [QW-1:0]             b,
        input logic [9:0]                i10,
        input logic [15:0]               i16
    );
        logic [31:0] ea;
        case (op)
            odd_pipe_pkg::lqd,
            odd_pipe_pkg::stqd: ea = a[QW-1 -: 32] + {{18{i10[9]}}, i10, 4'b0000};
            odd_pipe_pkg::lqx,
            odd_pipe_pkg::stqx: ea = a[QW-1 -: 32] + b[QW-1 -: 32];
            default:            ea = {{14{i16[15]}}, i16, 2'b00};
        endcase
        return ea[9:4];
    endfunction

    function automatic logic is_load_op(input odd_pipe_pkg::odd_opcode_t op);
        return op inside {odd_pipe_pkg::lqd, odd_pipe_pkg::lqx, odd_pipe_pkg::lqa};
    endfunction

    function automatic logic is_store_op(input odd_pipe_pkg::odd_opcode_t op);
        return op inside {odd_pipe_pkg::stqd, odd_pipe_pkg::stqx, odd_pipe_pkg::stqa};
    endfunction

    function automatic logic is_perm_op(input odd_pipe_pkg::odd_opcode_t op);
        return !(is_load_op(op) || is_store_op(op) || op == odd_pipe_pkg::lnop);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            pv <= '0;
            lv <= '0;
            for (int i = 0; i < odd_pipe_pkg::LS_DEPTH; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            pv <= {pv[PL-1:0], issue_valid && is_perm_op(opcode)};
            lv <= {lv[LL-1:0], issue_valid && is_load_op(opcode)};
            if (issue_valid && is_store_op(opcode)) begin
                shadow[ls_index(opcode, ra, rb, imm10, imm16)] <= rc;
            end
        end
    end

    always_ff @(posedge clk) begin
        pa[0] <= rt_addr;
        pd[0] <= perm_model(opcode, ra, rb, rc, imm7);
        la[0] <= rt_addr;
        ld[0] <= shadow[ls_index(opcode, ra, rb, imm10, imm16)];
        for (int i = 1; i <= PL; i++) begin
            pa[i] <= pa[i-1];
            pd[i] <= pd[i-1];
        end
        for (int i = 1; i <= LL; i++) begin
            la[i] <= la[i-1];
            ld[i] <= ld[i-1];
        end
    end

    perm_valid_check: assert property (
        @(posedge clk) disable iff (reset) perm_wb_valid == pv[PL])
    else begin
        errors++;
        $error("MISMATCH at %0t: perm_wb_valid got %b expected %b",
               $time, $sampled(perm_wb_valid), $sampled(pv[PL]));
    end

    perm_addr_check: assert property (
        @(posedge clk) disable iff (reset) perm_wb_valid |-> perm_wb_addr == pa[PL])
    else begin
        errors++;
        $error("MISMATCH at %0t: perm_wb_addr got %h expected %h",
               $time, $sampled(perm_wb_addr), $sampled(pa[PL]));
    end

    perm_data_check: assert property (
        @(posedge clk) disable iff (reset) perm_wb_valid |-> perm_wb_data == pd[PL])
    else begin
        errors++;
        $error("MISMATCH at %0t: perm_wb_data got %h expected %h",
               $time, $sampled(perm_wb_data), $sampled(pd[PL]));
    end

    ls_valid_check: assert property (
        @(posedge clk) disable iff (reset) ls_wb_valid == lv[LL])
    else begin
        errors++;
        $error("MISMATCH at %0t: ls_wb_valid got %b expected %b",
               $time, $sampled(ls_wb_valid), $sampled(lv[LL]));
    end

    ls_addr_check: assert property (
        @(posedge clk) disable iff (reset) ls_wb_valid |-> ls_wb_addr == la[LL])
    else begin
        errors++;
        $error("MISMATCH at %0t: ls_wb_addr got %h expected %h",
               $time, $sampled(ls_wb_addr), $sampled(la[LL]));
    end

    ls_data_check: assert property (
        @(posedge clk) disable iff (reset) ls_wb_valid |-> ls_wb_data == ld[LL])
    else begin
        errors++;
        $error("MISMATCH at %0t: ls_wb_data got %h expected %h",
               $time, $sampled(ls_wb_data), $sampled(ld[LL]));
    end

endmodule

bind odd_pipe_top odd_pipe_checker u_checker (.*);

//--- testbench/odd_pipe_tb.sv
//////////////////////////////////////////////////
// Odd pipe testbench
// LFSR driven issue stream for the permute and
// load/store units, checked by the bound checker
//////////////////////////////////////////////////

`timescale 1ns/1ps

module odd_pipe_tb;

    localparam int          QW          = odd_pipe_pkg::QUAD_W;
    localparam int          CYCLE_LIMIT = 1000;
    localparam int          MIX_ISSUES  = 400;
    localparam logic [31:0] LFSR_SEED   = 32'h14f3;

    logic                                clk;
    logic                                reset;
    logic                                issue_valid;
    odd_pipe_pkg::odd_opcode_t           opcode;
    logic [QW-1:0]                       ra;
    logic [QW-1:0]                       rb;
    logic [QW-1:0]                       rc;
    logic [odd_pipe_pkg::REG_ADDR_W-1:0] rt_addr;
    logic [odd_pipe_pkg::IMM7_W-1:0]     imm7;
    logic [odd_pipe_pkg::IMM10_W-1:0]    imm10;
    logic [odd_pipe_pkg::IMM16_W-1:0]    imm16;
    logic                                perm_wb_valid;
    logic [odd_pipe_pkg::REG_ADDR_W-1:0] perm_wb_addr;
    logic [QW-1:0]                       perm_wb_data;
    logic                                ls_wb_valid;
    logic [odd_pipe_pkg::REG_ADDR_W-1:0] ls_wb_addr;
    logic [QW-1:0]                       ls_wb_data;

    logic [31:0] lfsr_state;
    int          cycle_count;

    odd_pipe_pkg::odd_opcode_t shift_ops [10] = '{
        odd_pipe_pkg::shlqbi, odd_pipe_pkg::shlqbii, odd_pipe_pkg::shlqby,
        odd_pipe_pkg::shlqbyi, odd_pipe_pkg::shlqbybi, odd_pipe_pkg::rotqbi,
        odd_pipe_pkg::rotqbii, odd_pipe_pkg::rotqby, odd_pipe_pkg::rotqbyi,
        odd_pipe_pkg::rotqbybi
    };
    int edge_counts [4] = '{0, 15, 16, 31};

    odd_pipe_top uut (
        .clk           (clk),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .opcode        (opcode),
        .ra            (ra),
        .rb            (rb),
        .rc            (rc),
        .rt_addr       (rt_addr),
        .imm7          (imm7),
        .imm10         (imm10),
        .imm16         (imm16),
        .perm_wb_valid (perm_wb_valid),
        .perm_wb_addr  (perm_wb_addr),
        .perm_wb_data  (perm_wb_data),
        .ls_wb_valid   (ls_wb_valid),
        .ls_wb_addr    (ls_wb_addr),
        .ls_wb_data    (ls_wb_data)
    );

    always #50 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [QW-1:0] take_bits(input int n);
        logic [QW-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[QW-2:0], lfsr_state[31]};
        end
        return v;
    endfunction

    // Each control byte picks one of the four shuffle patterns
    function automatic logic [QW-1:0] shuffle_control();
        logic [QW-1:0] ctl;
        logic [1:0]    kind;
        logic [7:0]    b;
        ctl = '0;
        for (int j = 0; j < 16; j++) begin
            kind = 2'(take_bits(2));
            b    = 8'(take_bits(8));
            case (kind)
                2'd0:    b = {2'b10, b[5:0]};
                2'd1:    b = {3'b110, b[4:0]};
                2'd2:    b = {3'b111, b[4:0]};
                default: b = {1'b0, b[6:0]};
            endcase
            ctl[QW-1-8*j -: 8] = b;
        end
        return ctl;
    endfunction

    function automatic logic [31:0] count_word(
        input odd_pipe_pkg::odd_opcode_t op,
        input int                        c
    );
        if (op == odd_pipe_pkg::shlqbybi || op == odd_pipe_pkg::rotqbybi) begin
            return 32'(c) << 3;
        end
        return 32'(c);
    endfunction

    task automatic issue(
        input odd_pipe_pkg::odd_opcode_t op,
        input logic [QW-1:0]             a,
        input logic [QW-1:0]             b,
        input logic [QW-1:0]             c,
        input logic [6:0]                i7,
        input logic [9:0]                i10,
        input logic [15:0]               i16
    );
        @(posedge clk);
        #1;
        issue_valid = 1'b1;
        opcode      = op;
        ra          = a;
        rb          = b;
        rc          = c;
        imm7        = i7;
        imm10       = i10;
        imm16       = i16;
        rt_addr     = 7'(take_bits(7));
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            issue_valid = 1'b0;
            opcode      = odd_pipe_pkg::lnop;
        end
    endtask

    // Store, then load of the same address on the next cycle
    task automatic store_then_load(
        input odd_pipe_pkg::odd_opcode_t st_op,
        input odd_pipe_pkg::odd_opcode_t ld_op
    );
        logic [QW-1:0] a;
        logic [QW-1:0] b;
        logic [9:0]    i10;
        logic [15:0]   i16;
        a   = take_bits(QW);
        b   = take_bits(QW);
        i10 = 10'(take_bits(10));
        i16 = 16'(take_bits(16));
        issue(st_op, a, b, take_bits(QW), '0, i10, i16);
        issue(ld_op, a, b, take_bits(QW), '0, i10, i16);
    endtask

    task automatic finish_run(input int timeout_errors);
        int total;
        total = uut.u_checker.errors + timeout_errors;
        $display("Errors: %0d from checks, %0d from timeout, %0d total",
                 uut.u_checker.errors, timeout_errors, total);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            finish_run(1);
        end
    end

    initial begin
        logic [QW-1:0]             b;
        odd_pipe_pkg::odd_opcode_t op;
        int                        r;
        lfsr_state  = LFSR_SEED;
        cycle_count = 0;
        clk         = 1'b0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        opcode      = odd_pipe_pkg::lnop;
        ra          = '0;
        rb          = '0;
        rc          = '0;
        rt_addr     = '0;
        imm7        = '0;
        imm10       = '0;
        imm16       = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        idle(4);

        // Zero every local store index through a-form stores
        for (int i = 0; i < odd_pipe_pkg::LS_DEPTH; i++) begin
            issue(odd_pipe_pkg::stqa, '0, '0, '0, '0, '0, 16'(i * 4));
        end
        repeat (4) issue(odd_pipe_pkg::lnop, take_bits(QW), take_bits(QW), '0, '0, '0, '0);

        foreach (shift_ops[k]) begin
            foreach (edge_counts[m]) begin
                b = take_bits(QW);
                b[QW-1 -: 32] = count_word(shift_ops[k], edge_counts[m]);
                issue(shift_ops[k], take_bits(QW), b, take_bits(QW),
                      7'(edge_counts[m]), '0, '0);
            end
        end

        repeat (40) begin
            issue(odd_pipe_pkg::shufb, take_bits(QW), take_bits(QW), shuffle_control(),
                  '0, '0, '0);
        end

        repeat (8) begin
            store_then_load(odd_pipe_pkg::stqd, odd_pipe_pkg::lqd);
            store_then_load(odd_pipe_pkg::stqx, odd_pipe_pkg::lqx);
            store_then_load(odd_pipe_pkg::stqa, odd_pipe_pkg::lqa);
        end

        // Back to back random mix of every opcode
        for (int i = 0; i < MIX_ISSUES; i++) begin
            r  = int'(take_bits(5)) % 18;
            op = odd_pipe_pkg::odd_opcode_t'(r);
            issue(op, take_bits(QW), take_bits(QW), take_bits(QW),
                  7'(take_bits(7)), 10'(take_bits(10)), 16'(take_bits(16)));
        end

        idle(odd_pipe_pkg::LS_LATENCY + 3);
        finish_run(0);
    end

endmodule

//--- flist.f
rtl/odd_pipe_pkg.sv
rtl/quad_shift_rotate.sv
rtl/byte_shuffler.sv
rtl/permute_unit.sv
rtl/local_store_ram.sv
rtl/load_store_unit.sv
rtl/odd_pipe_top.sv
testbench/odd_pipe_checker.sv
testbench/odd_pipe_tb.sv

//--- Bender.yml
package:
  name: odd_pipe

sources:
  - files:
      - rtl/odd_pipe_pkg.sv
      - rtl/quad_shift_rotate.sv
      - rtl/byte_shuffler.sv
      - rtl/permute_unit.sv
      - rtl/local_store_ram.sv
      - rtl/load_store_unit.sv
      - rtl/odd_pipe_top.sv
  - target: test
    files:
      - testbench/odd_pipe_checker.sv
      - testbench/odd_pipe_tb.sv
